//--- usb_app.f
+incdir+source
source/usb_app_pkg.sv
source/rx_byte_buffer.sv
source/crc_lfsr_unit.sv
source/loop_ram.sv
source/app_ctrl.sv
source/usb_app.sv
verification/tb_clk_gen.sv
verification/tb_usb_app.sv

//--- run_sim.sh
#!/bin/sh
# Build the usb_app testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_usb_app \
   -f usb_app.f -o tb_usb_app || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_usb_app) || { echo "$sim_out"; echo "Simulation aborted"; exit 1; }
echo "$sim_out"
echo "$sim_out" | grep -qx "NO ERRORS" && echo "Result: pass" || { echo "Result: fail"; exit 1; }

//--- verification/tb_usb_app.sv
`timescale 1ns/1ps

module tb_usb_app;

   import usb_app_pkg::*;

   localparam crc_t  CRC_POLY = 32'h04C11DB7;
   localparam crc_t  CRC_INIT = 32'hFFFFFFFF;
   localparam lfsr_t LFSR_TAPS = 24'hE10000;
   localparam int    WAIT_LIMIT = 400;
   localparam int    NUM_ROWS = 15;

   localparam logic [3:0] OP_ECHO = 4'd0;
   localparam logic [3:0] OP_ADDR = 4'd1;
   localparam logic [3:0] OP_WAIT = 4'd2;
   localparam logic [3:0] OP_LFSR_WRITE = 4'd3;
   localparam logic [3:0] OP_LFSR_READ = 4'd4;
   localparam logic [3:0] OP_IN = 4'd5;
   localparam logic [3:0] OP_OUT = 4'd6;
   localparam logic [3:0] OP_RAM_READ = 4'd7;
   localparam logic [3:0] OP_UNKNOWN = 4'd8;

   typedef struct packed {
      logic [3:0]  op;
      logic [23:0] arg;
   } row_t;

   // Arg is a byte count, address, delay, seed, transfer count or command code
   row_t rows [NUM_ROWS] = '{
      '{OP_ECHO, 24'd8},
      '{OP_ADDR, 24'd0},
      '{OP_ECHO, 24'd12},
      '{OP_ADDR, 24'd0},
      '{OP_RAM_READ, 24'd11},
      '{OP_LFSR_WRITE, 24'h5A3C91},
      '{OP_LFSR_READ, 24'd0},
      '{OP_IN, 24'd19},
      '{OP_OUT, 24'd15},
      '{OP_UNKNOWN, 24'h000007},
      '{OP_ECHO, 24'd5},
      '{OP_WAIT, 24'd3},
      '{OP_IN, 24'd9},
      '{OP_WAIT, 24'd0},
      '{OP_LFSR_READ, 24'd0}
   };

   logic  clk_i;
   logic  rstn = 1'b0;
   byte_t out_data_i = 8'h00;
   logic  out_valid_i = 1'b0;
   logic  out_ready_o;
   byte_t in_data_o;
   logic  in_valid_o;
   logic  in_ready_i = 1'b0;

   byte_t mem_model [1024];
   addr_t addr_model = '0;
   lfsr_t lfsr_model = '0;
   wait_t wait_model = '0;
   byte_t send_q [$];
   byte_t exp_q [$];
   byte_t got_q [$];
   int    stamp_q [$];
   int    cycle_cnt = 0;
   int    errors = 0;
   int    checks = 0;
   logic  timed_out = 1'b0;

   tb_clk_gen clk_gen0 (
      .clk_o (clk_i)
   );

   usb_app dut0 (
      .clk_i       (clk_i),
      .rstn        (rstn),
      .out_data_i  (out_data_i),
      .out_valid_i (out_valid_i),
      .out_ready_o (out_ready_o),
      .in_data_o   (in_data_o),
      .in_valid_o  (in_valid_o),
      .in_ready_i  (in_ready_i)
   );

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Host back-pressure with ready about three cycles in four
   always @(negedge clk_i) begin
      in_ready_i = ($urandom_range(3) != 0);
   end

   // One byte of CRC32 with data bit 0 first
   function automatic crc_t crc_step(crc_t crc, byte_t data);
      crc_t c;
      c = crc;
      for (int k = 0; k < 8; k++) begin
         if ((data[k] ^ c[31]) == 1'b1) begin
            c = (c << 1) ^ CRC_POLY;
         end else begin
            c = c << 1;
         end
      end
      return c;
   endfunction

   function automatic lfsr_t lfsr_next(lfsr_t s);
      logic fb;
      fb = 1'b1;
      for (int k = 0; k < 24; k++) begin
         if (LFSR_TAPS[k]) begin
            fb = fb ^ s[k];
         end
      end
      return {s[22:0], fb};
   endfunction

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      errors++;
      timed_out = 1'b1;
      $display("Timeout: %s", what);
   endtask

   task automatic push_cmd(input byte_t code, input logic [23:0] arg);
      send_q.push_back(8'h00);
      send_q.push_back(code);
      send_q.push_back(arg[7:0]);
      send_q.push_back(arg[15:8]);
      send_q.push_back(arg[23:16]);
   endtask

   // Final checksum goes out inverted with each byte bit-reversed and the top byte first
   task automatic push_crc_bytes(input crc_t crc);
      crc_t  inv;
      byte_t b;
      byte_t r;
      inv = ~crc;
      for (int i = 3; i >= 0; i--) begin
         b = inv[8*i +: 8];
         r = {<<{b}};
         exp_q.push_back(r);
      end
   endtask

   task automatic build_row(input row_t r);
      crc_t  crc;
      byte_t b;
      send_q.delete();
      exp_q.delete();
      case (r.op)
         OP_ECHO: begin
            for (int i = 0; i < int'(r.arg); i++) begin
               b = 8'($urandom_range(255, 1));
               send_q.push_back(b);
               exp_q.push_back(b);
               mem_model[addr_model[9:0]] = b;
               addr_model = addr_model + 24'd1;
            end
         end
         OP_ADDR: begin
            push_cmd(CMD_ADDR, r.arg);
            addr_model = r.arg;
         end
         OP_WAIT: begin
            send_q.push_back(8'h00);
            send_q.push_back(CMD_WAIT);
            send_q.push_back(r.arg[7:0]);
            wait_model = r.arg[7:0];
         end
         OP_LFSR_WRITE: begin
            push_cmd(CMD_LFSR_WRITE, r.arg);
            lfsr_model = r.arg;
         end
         OP_LFSR_READ: begin
            send_q.push_back(8'h00);
            send_q.push_back(CMD_LFSR_READ);
            exp_q.push_back(lfsr_model[7:0]);
            exp_q.push_back(lfsr_model[15:8]);
            exp_q.push_back(lfsr_model[23:16]);
            exp_q.push_back(8'h00);
         end
         OP_IN: begin
            push_cmd(CMD_IN, r.arg);
            crc = CRC_INIT;
            for (int i = 0; i <= int'(r.arg); i++) begin
               exp_q.push_back(lfsr_model[7:0]);
               crc = crc_step(crc, lfsr_model[7:0]);
               lfsr_model = lfsr_next(lfsr_model);
            end
            push_crc_bytes(crc);
         end
         OP_OUT: begin
            push_cmd(CMD_OUT, r.arg);
            crc = CRC_INIT;
            for (int i = 0; i <= int'(r.arg); i++) begin
               b = 8'($urandom_range(255, 0));
               send_q.push_back(b);
               crc = crc_step(crc, b);
            end
            push_crc_bytes(crc);
         end
         OP_RAM_READ: begin
            push_cmd(CMD_RAM_READ, r.arg);
            for (int i = 0; i <= int'(r.arg); i++) begin
               exp_q.push_back(mem_model[addr_model[9:0]]);
               addr_model = addr_model + 24'd1;
            end
            addr_model = '0;
         end
         default: begin
            send_q.push_back(8'h00);
            send_q.push_back(r.arg[7:0]);
         end
      endcase
   endtask

   // Outputs are sampled 1 ns after the falling edge and hold until the rising edge
   task automatic send_all();
      int guard;
      for (int i = 0; i < send_q.size(); i++) begin
         @(negedge clk_i);
         out_data_i = send_q[i];
         out_valid_i = 1'b1;
         guard = 0;
         #1;
         while (!out_ready_o) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
               report_timeout("out_ready_o stayed low while a byte was offered");
               return;
            end
            @(negedge clk_i);
            #1;
         end
      end
      @(negedge clk_i);
      out_valid_i = 1'b0;
   endtask

   task automatic collect_all(input int n);
      int guard;
      got_q.delete();
      stamp_q.delete();
      for (int i = 0; i < n; i++) begin
         guard = 0;
         @(negedge clk_i);
         #1;
         while (!(in_valid_o && in_ready_i)) begin
            guard++;
            if (guard > WAIT_LIMIT) begin
               report_timeout("expected reply byte never arrived on the in stream");
               return;
            end
            @(negedge clk_i);
            #1;
         end
         got_q.push_back(in_data_o);
         stamp_q.push_back(cycle_cnt);
      end
   endtask

   task automatic compare_row(input int idx, input row_t r);
      int gap;
      for (int i = 0; i < exp_q.size(); i++) begin
         checks++;
         if (got_q[i] !== exp_q[i]) begin
            errors++;
            $display("** Error: row %0d in_data_o byte %0d: got 0x%02h, expected 0x%02h",
                     idx, i, got_q[i], exp_q[i]);
         end
      end
      // LFSR bytes of a paced IN keep at least W+1 cycles between transfers
      if ((r.op == OP_IN) && (wait_model != '0)) begin
         for (int i = 1; i <= int'(r.arg); i++) begin
            gap = stamp_q[i] - stamp_q[i-1];
            checks++;
            if (gap < int'(wait_model) + 1) begin
               errors++;
               $display(
                  "** Error: row %0d in_valid_o gap at byte %0d: got 0x%0h, expected >= 0x%0h",
                  idx, i, gap, int'(wait_model) + 1);
            end
         end
      end
   endtask

   task automatic expect_idle(input int idx, input int n);
      for (int k = 0; k < n; k++) begin
         @(negedge clk_i);
         #1;
         checks++;
         if (in_valid_o !== 1'b0) begin
            errors++;
            $display("** Error: row %0d in_valid_o while idle: got 0x%0h, expected 0x0",
                     idx, in_valid_o);
         end
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("** Error: %s after reset: got 0x%0h, expected 0x%0h", name, got, want);
      end
   endtask

   initial begin
      void'($urandom(32'he3f629ea));
      repeat (16) @(negedge clk_i);
      rstn = 1'b1;
      @(negedge clk_i);
      #1;
      check_bit("in_valid_o", in_valid_o, 1'b0);
      check_bit("out_ready_o", out_ready_o, 1'b1);
      for (int r = 0; r < NUM_ROWS; r++) begin
         build_row(rows[r]);
         fork
            send_all();
            collect_all(exp_q.size());
         join
         if (timed_out) begin
            break;
         end
         compare_row(r, rows[r]);
         expect_idle(r, 6);
      end
      finish_run();
   end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o
);

   // 4 ns period, first rising edge at 2 ns
   initial begin
      clk_o = 1'b0;
      forever begin
         #2 clk_o = ~clk_o;
      end
   end

endmodule

//--- source/usb_app.sv
`timescale 1ns/1ps

module usb_app (
   input  logic               clk_i,
   input  logic               rstn,
   input  usb_app_pkg::byte_t out_data_i,
   input  logic               out_valid_i,
   output logic               out_ready_o,
   output usb_app_pkg::byte_t in_data_o,
   output logic               in_valid_o,
   input  logic               in_ready_i
);

   import usb_app_pkg::*;

   byte_t     rx_data;
   logic      rx_valid;
   logic      rx_pop;
   logic      pause;
   logic      crc_init;
   logic      crc_update;
   byte_t     crc_data;
   logic      lfsr_load;
   logic [1:0] lfsr_lane;
   byte_t     lfsr_data;
   logic      lfsr_step;
   crc_t      crc_result;
   lfsr_t     lfsr;
   logic      ram_en;
   logic      ram_we;
   ram_addr_t ram_addr;
   byte_t     ram_rdata;

   rx_byte_buffer u_rx_buf (
      .clk_i       (clk_i),
      .rstn        (rstn),
      .out_data_i  (out_data_i),
      .out_valid_i (out_valid_i),
      .out_ready_o (out_ready_o),
      .pause_i     (pause),
      .pop_i       (rx_pop),
      .data_o      (rx_data),
      .valid_o     (rx_valid)
   );

   crc_lfsr_unit u_crc_lfsr (
      .clk_i        (clk_i),
      .rstn         (rstn),
      .crc_init_i   (crc_init),
      .crc_update_i (crc_update),
      .crc_data_i   (crc_data),
      .lfsr_load_i  (lfsr_load),
      .lfsr_lane_i  (lfsr_lane),
      .lfsr_data_i  (lfsr_data),
      .lfsr_step_i  (lfsr_step),
      .crc_result_o (crc_result),
      .lfsr_o       (lfsr)
   );

   // Received bytes are the write data of the loopback capture
   loop_ram u_ram (
      .clk_i   (clk_i),
      .en_i    (ram_en),
      .we_i    (ram_we),
      .addr_i  (ram_addr),
      .wdata_i (rx_data),
      .rdata_o (ram_rdata)
   );

   app_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rstn         (rstn),
      .rx_data_i    (rx_data),
      .rx_valid_i   (rx_valid),
      .rx_pop_o     (rx_pop),
      .pause_o      (pause),
      .in_data_o    (in_data_o),
      .in_valid_o   (in_valid_o),
      .in_ready_i   (in_ready_i),
      .crc_init_o   (crc_init),
      .crc_update_o (crc_update),
      .crc_data_o   (crc_data),
      .lfsr_load_o  (lfsr_load),
      .lfsr_lane_o  (lfsr_lane),
      .lfsr_data_o  (lfsr_data),
      .lfsr_step_o  (lfsr_step),
      .lfsr_i       (lfsr),
      .crc_result_i (crc_result),
      .ram_en_o     (ram_en),
      .ram_we_o     (ram_we),
      .ram_addr_o   (ram_addr),
      .ram_rdata_i  (ram_rdata)
   );

endmodule

//--- source/app_ctrl.sv
`timescale 1ns/1ps

module app_ctrl (
   input  logic                   clk_i,
   input  logic                   rstn,
   input  usb_app_pkg::byte_t     rx_data_i,
   input  logic                   rx_valid_i,
   output logic                   rx_pop_o,
   output logic                   pause_o,
   output usb_app_pkg::byte_t     in_data_o,
   output logic                   in_valid_o,
   input  logic                   in_ready_i,
   output logic                   crc_init_o,
   output logic                   crc_update_o,
   output usb_app_pkg::byte_t     crc_data_o,
   output logic                   lfsr_load_o,
   output logic [1:0]             lfsr_lane_o,
   output usb_app_pkg::byte_t     lfsr_data_o,
   output logic                   lfsr_step_o,
   input  usb_app_pkg::lfsr_t     lfsr_i,
   input  usb_app_pkg::crc_t      crc_result_i,
   output logic                   ram_en_o,
   output logic                   ram_we_o,
   output usb_app_pkg::ram_addr_t ram_addr_o,
   input  usb_app_pkg::byte_t     ram_rdata_i
);

   import usb_app_pkg::*;

   app_state_e state_q, state_d;
   app_cmd_e   cmd_q, cmd_d;
   count_t     count_q, count_d;
   addr_t      addr_q, addr_d;
   wait_t      wait_q, wait_d;
   wait_t      wait_cnt_q;
   logic       mem_valid_q, mem_valid_d;
   logic       wait_load;
   logic       in_valid;
   logic       rx_valid;
   logic       tx_ready;
   crc_t       reply_word;

   // Both streams stall while the pacing counter runs
   assign pause_o = (wait_cnt_q != '0);
   assign rx_valid = rx_valid_i & ~pause_o;
   assign tx_ready = in_ready_i & ~pause_o;
   assign in_valid_o = in_valid & ~pause_o;

   assign lfsr_data_o = rx_data_i;
   assign ram_addr_o = ram_addr_t'(addr_q);

   // LFSR readback ends with a zero byte
   assign reply_word = (cmd_q == CMD_LFSR_READ) ?
                       {lfsr_i[7:0], lfsr_i[15:8], lfsr_i[23:16], 8'h00} : crc_result_i;

   always_comb begin
      state_d = state_q;
      cmd_d = cmd_q;
      count_d = count_q;
      addr_d = addr_q;
      wait_d = wait_q;
      mem_valid_d = mem_valid_q;
      wait_load = 1'b0;
      rx_pop_o = 1'b0;
      in_data_o = rx_data_i;
      in_valid = 1'b0;
      crc_init_o = 1'b0;
      crc_update_o = 1'b0;
      crc_data_o = rx_data_i;
      lfsr_load_o = 1'b0;
      lfsr_lane_o = 2'd0;
      lfsr_step_o = 1'b0;
      ram_en_o = 1'b0;
      ram_we_o = 1'b0;

      case (state_q)
         ST_LOOPBACK: begin
            if (rx_valid) begin
               if (rx_data_i == CMD_ESC) begin
                  rx_pop_o = 1'b1;
                  state_d = ST_CMD0;
               end else begin
                  // Echo and capture together, only once the host takes it
                  in_valid = 1'b1;
                  rx_pop_o = tx_ready;
                  if (tx_ready) begin
                     ram_en_o = 1'b1;
                     ram_we_o = 1'b1;
                     addr_d = addr_q + 24'd1;
                  end
               end
            end
         end
         ST_CMD0: begin
            if (rx_valid) begin
               rx_pop_o = 1'b1;
               cmd_d = app_cmd_e'(rx_data_i);
               state_d = ST_CMD1;
            end
         end
         ST_CMD1: begin
            case (cmd_q)
               CMD_WAIT: begin
                  if (rx_valid) begin
                     rx_pop_o = 1'b1;
                     wait_d = rx_data_i;
                     state_d = ST_LOOPBACK;
                  end
               end
               CMD_LFSR_READ: begin
                  state_d = ST_READ0;
               end
               CMD_IN, CMD_OUT, CMD_ADDR, CMD_LFSR_WRITE, CMD_RAM_READ: begin
                  if (rx_valid) begin
                     rx_pop_o = 1'b1;
                     state_d = ST_CMD2;
                  end
               end
               default: begin
                  state_d = ST_LOOPBACK;
               end
            endcase
         end
         ST_CMD2: begin
            if (rx_valid) begin
               rx_pop_o = 1'b1;
               state_d = ST_CMD3;
            end
         end
         ST_CMD3: begin
            if (rx_valid) begin
               rx_pop_o = 1'b1;
               case (cmd_q)
                  CMD_IN: begin
                     crc_init_o = 1'b1;
                     state_d = ST_IN;
                  end
                  CMD_OUT: begin
                     crc_init_o = 1'b1;
                     state_d = ST_OUT;
                  end
                  CMD_RAM_READ: state_d = ST_READ_RAM;
                  default: state_d = ST_LOOPBACK;
               endcase
            end
         end
         ST_IN: begin
            in_data_o = lfsr_i[7:0];
            in_valid = 1'b1;
            if (tx_ready) begin
               crc_update_o = 1'b1;
               crc_data_o = lfsr_i[7:0];
               lfsr_step_o = 1'b1;
               wait_load = 1'b1;
               if (count_q == '0) begin
                  state_d = ST_READ0;
               end else begin
                  count_d = count_q - 24'd1;
               end
            end
         end
         ST_OUT: begin
            if (rx_valid) begin
               rx_pop_o = 1'b1;
               crc_update_o = 1'b1;
               wait_load = 1'b1;
               if (count_q == '0) begin
                  state_d = ST_READ0;
               end else begin
                  count_d = count_q - 24'd1;
               end
            end
         end
         ST_READ0: begin
            in_data_o = reply_word[31:24];
            in_valid = 1'b1;
            if (tx_ready) begin
               state_d = ST_READ1;
            end
         end
         ST_READ1: begin
            in_data_o = reply_word[23:16];
            in_valid = 1'b1;
            if (tx_ready) begin
               state_d = ST_READ2;
            end
         end
         ST_READ2: begin
            in_data_o = reply_word[15:8];
            in_valid = 1'b1;
            if (tx_ready) begin
               state_d = ST_READ3;
            end
         end
         ST_READ3: begin
            in_data_o = reply_word[7:0];
            in_valid = 1'b1;
            if (tx_ready) begin
               state_d = ST_LOOPBACK;
            end
         end
         ST_READ_RAM: begin
            in_data_o = ram_rdata_i;
            in_valid = mem_valid_q;
            if (!mem_valid_q) begin
               // Fetch, data is on rdata next cycle
               ram_en_o = 1'b1;
               mem_valid_d = 1'b1;
               addr_d = addr_q + 24'd1;
            end else if (tx_ready) begin
               mem_valid_d = 1'b0;
               wait_load = 1'b1;
               if (count_q == '0) begin
                  state_d = ST_LOOPBACK;
                  addr_d = '0;
               end else begin
                  count_d = count_q - 24'd1;
               end
            end
         end
         default: begin
            state_d = ST_LOOPBACK;
         end
      endcase

      // Arguments arrive low byte first and shift in from the top
      if (rx_pop_o && (state_q inside {ST_CMD1, ST_CMD2, ST_CMD3})) begin
         case (cmd_q)
            CMD_IN, CMD_OUT, CMD_RAM_READ: count_d = {rx_data_i, count_q[23:8]};
            CMD_ADDR: addr_d = {rx_data_i, addr_q[23:8]};
            CMD_LFSR_WRITE: begin
               lfsr_load_o = 1'b1;
               lfsr_lane_o = (state_q == ST_CMD1) ? 2'd0 :
                             (state_q == ST_CMD2) ? 2'd1 : 2'd2;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q <= ST_LOOPBACK;
         cmd_q <= CMD_ESC;
         count_q <= '0;
         addr_q <= '0;
         wait_q <= '0;
         wait_cnt_q <= '0;
         mem_valid_q <= 1'b0;
      end else begin
         state_q <= state_d;
         cmd_q <= cmd_d;
         count_q <= count_d;
         addr_q <= addr_d;
         wait_q <= wait_d;
         mem_valid_q <= mem_valid_d;
         if (wait_cnt_q != '0) begin
            wait_cnt_q <= wait_cnt_q - 8'd1;
         end else if (wait_load) begin
            wait_cnt_q <= wait_q;
         end
      end
   end

   // A paced IN byte is followed by a quiet gap on the in stream
   a_in_paced: assert property (
      @(posedge clk_i) disable iff (!rstn)
      (state_q == ST_IN) && in_valid_o && in_ready_i && (wait_q != '0)
      |=> pause_o && !in_valid_o
   );

endmodule

//--- source/loop_ram.sv
`timescale 1ns/1ps
`include "usb_app_settings.svh"

module loop_ram #(
   parameter int DEPTH = `USB_APP_RAM_SIZE
) (
   input  logic                   clk_i,
   input  logic                   en_i,
   input  logic                   we_i,
   input  usb_app_pkg::ram_addr_t addr_i,
   input  usb_app_pkg::byte_t     wdata_i,
   output usb_app_pkg::byte_t     rdata_o
);

   import usb_app_pkg::*;

   byte_t mem_q [DEPTH];

   // Single port, read data registered one cycle after the enable
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem_q[addr_i] <= wdata_i;
         end else begin
            rdata_o <= mem_q[addr_i];
         end
      end
   end

   // Controller address must stay inside a smaller array
   a_addr_range: assert property (
      @(posedge clk_i)
      en_i |-> (int'(addr_i) < DEPTH)
   );

endmodule

//--- source/crc_lfsr_unit.sv
`timescale 1ns/1ps
`include "usb_app_settings.svh"

module crc_lfsr_unit (
   input  logic                clk_i,
   input  logic                rstn,
   input  logic                crc_init_i,
   input  logic                crc_update_i,
   input  usb_app_pkg::byte_t  crc_data_i,
   input  logic                lfsr_load_i,
   input  logic [1:0]          lfsr_lane_i,
   input  usb_app_pkg::byte_t  lfsr_data_i,
   input  logic                lfsr_step_i,
   output usb_app_pkg::crc_t   crc_result_o,
   output usb_app_pkg::lfsr_t  lfsr_o
);

   import usb_app_pkg::*;

   crc_t  crc_q;
   lfsr_t lfsr_q;

   // Bit-serial update, data bit 0 enters first
   function automatic crc_t crc32_byte(byte_t data, crc_t crc);
      crc_t c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (data[i] ^ c[31]) begin
            c = {c[30:0], 1'b0} ^ `USB_APP_CRC_POLY;
         end else begin
            c = {c[30:0], 1'b0};
         end
      end
      return c;
   endfunction

   function automatic byte_t rev8(byte_t data);
      byte_t r;
      for (int i = 0; i < 8; i++) begin
         r[i] = data[7-i];
      end
      return r;
   endfunction

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         crc_q <= `USB_APP_CRC_INIT;
         lfsr_q <= '0;
      end else begin
         if (crc_init_i) begin
            crc_q <= `USB_APP_CRC_INIT;
         end else if (crc_update_i) begin
            crc_q <= crc32_byte(crc_data_i, crc_q);
         end
         if (lfsr_load_i) begin
            case (lfsr_lane_i)
               2'd0: lfsr_q[7:0] <= lfsr_data_i;
               2'd1: lfsr_q[15:8] <= lfsr_data_i;
               2'd2: lfsr_q[23:16] <= lfsr_data_i;
               default: lfsr_q <= lfsr_q;
            endcase
         end else if (lfsr_step_i) begin
            lfsr_q <= {lfsr_q[22:0], ~^(lfsr_q & `USB_APP_LFSR_TAPS)};
         end
      end
   end

   // Checksum as sent on the wire, top byte goes out first
   assign crc_result_o = {rev8(~crc_q[31:24]), rev8(~crc_q[23:16]),
                          rev8(~crc_q[15:8]), rev8(~crc_q[7:0])};
   assign lfsr_o = lfsr_q;

   a_crc_strobes: assert property (
      @(posedge clk_i) disable iff (!rstn)
      !(crc_init_i && crc_update_i)
   );

endmodule

//--- source/rx_byte_buffer.sv
`timescale 1ns/1ps

module rx_byte_buffer (
   input  logic                clk_i,
   input  logic                rstn,
   input  usb_app_pkg::byte_t  out_data_i,
   input  logic                out_valid_i,
   output logic                out_ready_o,
   input  logic                pause_i,
   input  logic                pop_i,
   output usb_app_pkg::byte_t  data_o,
   output logic                valid_o
);

   import usb_app_pkg::*;

   byte_t data_q;
   logic  full_q;
   logic  load;

   // Room when empty or emptied this cycle, none while pacing
   assign out_ready_o = (~full_q | pop_i) & ~pause_i;
   assign load = out_valid_i & out_ready_o;

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         full_q <= 1'b0;
      end else if (load) begin
         full_q <= 1'b1;
      end else if (pop_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         data_q <= out_data_i;
      end
   end

   assign data_o = data_q;
   assign valid_o = full_q;

   // A held byte must not change until the controller takes it
   a_hold_stable: assert property (
      @(posedge clk_i) disable iff (!rstn)
      valid_o && !pop_i |=> valid_o && $stable(data_o)
   );

endmodule

//--- source/usb_app_pkg.sv
`include "usb_app_settings.svh"

package usb_app_pkg;

   typedef logic [7:0] byte_t;

   // Transfer length minus one
   typedef logic [23:0] count_t;

   typedef logic [23:0] addr_t;
   typedef logic [`USB_APP_RAM_AW-1:0] ram_addr_t;
   typedef logic [31:0] crc_t;
   typedef logic [23:0] lfsr_t;

   // Idle cycles after each data byte
   typedef logic [7:0] wait_t;

   // CMD_ESC is also the escape byte that starts command mode
   typedef enum logic [7:0] {
      CMD_ESC        = 8'h00,
      CMD_IN         = 8'h01,
      CMD_OUT        = 8'h02,
      CMD_ADDR       = 8'h03,
      CMD_WAIT       = 8'h04,
      CMD_LFSR_WRITE = 8'h05,
      CMD_LFSR_READ  = 8'h06,
      CMD_RAM_READ   = 8'h08
   } app_cmd_e;

   typedef enum logic [3:0] {
      ST_LOOPBACK,
      ST_CMD0,
      ST_CMD1,
      ST_CMD2,
      ST_CMD3,
      ST_IN,
      ST_OUT,
      ST_READ0,
      ST_READ1,
      ST_READ2,
      ST_READ3,
      ST_READ_RAM
   } app_state_e;

endpackage

//--- source/usb_app_settings.svh
`ifndef USB_APP_SETTINGS_SVH
`define USB_APP_SETTINGS_SVH

// Loopback capture RAM
`define USB_APP_RAM_SIZE 1024
`define USB_APP_RAM_AW 10

// CRC32 polynomial and start value
`define USB_APP_CRC_POLY 32'h04C11DB7
`define USB_APP_CRC_INIT 32'hFFFFFFFF

// Taps of the 24-bit LFSR, feedback is the XNOR of the selected bits
`define USB_APP_LFSR_TAPS 24'hE10000

`endif
